// File: hdl/preg_pkg.sv
package preg_pkg;

  // ------------------------------------------------------------------
  // Slot counts and field widths
  // ------------------------------------------------------------------
  localparam int DISPATCH_SLOTS = 4;
  localparam int RETIRE_SLOTS   = 3;

  localparam int IID_W  = 7;
  localparam int AREG_W = 5;
  localparam int PREG_W = 7;

  // Lengths of the one-hot release and recovery vectors
  localparam int PREG_NUM = 96;
  localparam int AREG_NUM = 32;

  // ------------------------------------------------------------------
  // Field types
  // ------------------------------------------------------------------
  typedef logic [IID_W-1:0]  iid_t;
  typedef logic [AREG_W-1:0] areg_t;
  typedef logic [PREG_W-1:0] preg_t;

  // ------------------------------------------------------------------
  // State encodings
  // ------------------------------------------------------------------
  // Lifecycle of one physical register, one-hot
  //   DEALLOC   free, may be handed out again
  //   WF_ALLOC  sitting in the allocation queue
  //   ALLOC     owned by an in-flight producer
  //   RETIRE    producer retired, register still mapped
  //   RELEASE   released but write-back still pending
  typedef enum logic [4:0] {
    DEALLOC  = 5'b00001,
    WF_ALLOC = 5'b00010,
    ALLOC    = 5'b00100,
    RETIRE   = 5'b01000,
    RELEASE  = 5'b10000
  } lifecycle_e;

  // Write-back status of the register value
  typedef enum logic {
    IDLE = 1'b0,
    WB   = 1'b1
  } wb_e;

endpackage

// File: hdl/dispatch_capture.sv
module dispatch_capture (
  input  logic                sm_clk,
  input  logic                cpurst_b,
  input  logic [preg_pkg::DISPATCH_SLOTS-1:0] create_sel,
  input  preg_pkg::iid_t      dis_iid      [preg_pkg::DISPATCH_SLOTS],
  input  preg_pkg::areg_t     dis_dst_reg  [preg_pkg::DISPATCH_SLOTS],
  input  preg_pkg::preg_t     dis_rel_preg [preg_pkg::DISPATCH_SLOTS],
  output logic                create_vld,
  output preg_pkg::iid_t      iid,
  output preg_pkg::areg_t     dst_reg,
  output preg_pkg::preg_t     rel_preg
);

  preg_pkg::iid_t  sel_iid;
  preg_pkg::areg_t sel_dst_reg;
  preg_pkg::preg_t sel_rel_preg;

  assign create_vld = |create_sel;

  // Slot mux, select is one-hot so an OR of the chosen fields is enough
  always_comb begin
    sel_iid      = '0;
    sel_dst_reg  = '0;
    sel_rel_preg = '0;
    for (int i = 0; i < preg_pkg::DISPATCH_SLOTS; i++) begin
      if (create_sel[i]) begin
        sel_iid      = sel_iid | dis_iid[i];
        sel_dst_reg  = sel_dst_reg | dis_dst_reg[i];
        sel_rel_preg = sel_rel_preg | dis_rel_preg[i];
      end
    end
  end

  // ------------------------------------------------------------------
  // Entry information registers
  // ------------------------------------------------------------------
  always_ff @(posedge sm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      iid      <= '0;
      dst_reg  <= '0;
      rel_preg <= '0;
    end else if (create_vld) begin
      iid      <= sel_iid;
      dst_reg  <= sel_dst_reg;
      rel_preg <= sel_rel_preg;
    end
  end

  // Dispatch never hands the same register to two slots at once
  a_create_sel_onehot0 : assert property (
    @(posedge sm_clk) disable iff (!cpurst_b)
    $onehot0(create_sel)
  );

endmodule

// File: hdl/retire_match.sv
module retire_match (
  input  logic                sm_clk,
  input  logic                cpurst_b,
  input  logic                alloc_state,
  input  preg_pkg::iid_t      iid,
  input  logic [preg_pkg::RETIRE_SLOTS-1:0] retire_updt_vld,
  input  preg_pkg::iid_t      retire_updt_iid [preg_pkg::RETIRE_SLOTS],
  input  logic [preg_pkg::RETIRE_SLOTS-1:0] retire_preg_vld,
  output logic                retire_vld
);

  logic [preg_pkg::RETIRE_SLOTS-1:0] match;
  logic [preg_pkg::RETIRE_SLOTS-1:0] match_updt;
  logic [preg_pkg::RETIRE_SLOTS-1:0] slot_hit;

  // ------------------------------------------------------------------
  // Early id compare
  // ------------------------------------------------------------------
  // Done one cycle ahead of the retire to keep the compare off the
  // path from retire valid to the release request
  always_comb begin
    for (int k = 0; k < preg_pkg::RETIRE_SLOTS; k++) begin
      match_updt[k] = alloc_state && (iid == retire_updt_iid[k]);
    end
  end

  // Flag only moves when its slot presents a new id
  always_ff @(posedge sm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      match <= '0;
    end else begin
      for (int k = 0; k < preg_pkg::RETIRE_SLOTS; k++) begin
        if (retire_updt_vld[k]) begin
          match[k] <= match_updt[k];
        end
      end
    end
  end

  // ------------------------------------------------------------------
  // Retire confirm
  // ------------------------------------------------------------------
  assign slot_hit   = retire_preg_vld & match;
  assign retire_vld = |slot_hit;

endmodule

// File: hdl/preg_lifecycle_fsm.sv
module preg_lifecycle_fsm (
  input  logic sm_clk,
  input  logic cpurst_b,
  input  logic flush,
  input  logic dealloc_vld,
  input  logic create_vld,
  input  logic retire_vld,
  input  logic release_vld,
  input  logic wb_done,
  output logic dealloc_state,
  output logic alloc_state,
  output logic retire_state,
  output logic release_state
);

  preg_pkg::lifecycle_e state;
  preg_pkg::lifecycle_e next_state;

  always_ff @(posedge sm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      state <= preg_pkg::DEALLOC;
    end else begin
      state <= next_state;
    end
  end

  // ------------------------------------------------------------------
  // Transition rules
  // ------------------------------------------------------------------
  // Flush wins over every other event in the states it applies to
  always_comb begin
    next_state = state;
    case (state)
      preg_pkg::DEALLOC: begin
        if (dealloc_vld && !flush) begin
          next_state = preg_pkg::WF_ALLOC;
        end
      end
      preg_pkg::WF_ALLOC: begin
        if (flush) begin
          next_state = preg_pkg::DEALLOC;
        end else if (create_vld) begin
          next_state = preg_pkg::ALLOC;
        end
      end
      preg_pkg::ALLOC: begin
        if (flush) begin
          next_state = preg_pkg::DEALLOC;
        end else if (release_vld) begin
          next_state = wb_done ? preg_pkg::DEALLOC : preg_pkg::RELEASE;
        end else if (retire_vld) begin
          next_state = preg_pkg::RETIRE;
        end
      end
      preg_pkg::RETIRE: begin
        if (release_vld) begin
          next_state = wb_done ? preg_pkg::DEALLOC : preg_pkg::RELEASE;
        end
      end
      preg_pkg::RELEASE: begin
        // Wait for the last write-back before freeing
        if (wb_done) begin
          next_state = preg_pkg::DEALLOC;
        end
      end
      default: begin
        next_state = preg_pkg::DEALLOC;
      end
    endcase
  end

  assign dealloc_state = (state == preg_pkg::DEALLOC);
  assign alloc_state   = (state == preg_pkg::ALLOC);
  assign retire_state  = (state == preg_pkg::RETIRE);
  assign release_state = (state == preg_pkg::RELEASE);

  a_state_onehot : assert property (
    @(posedge sm_clk) disable iff (!cpurst_b)
    $onehot(state)
  );

endmodule

// File: hdl/preg_wb_fsm.sv
module preg_wb_fsm (
  input  logic sm_clk,
  input  logic cpurst_b,
  input  logic wb_vld,
  input  logic create_vld,
  input  logic dealloc_state,
  output logic wb_done
);

  preg_pkg::wb_e state;
  preg_pkg::wb_e next_state;

  // A new producer always starts out not written back
  always_ff @(posedge sm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      state <= preg_pkg::IDLE;
    end else if (create_vld) begin
      state <= preg_pkg::IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      preg_pkg::IDLE: begin
        if (wb_vld) begin
          next_state = preg_pkg::WB;
        end
      end
      preg_pkg::WB: begin
        // Back to idle once the lifecycle has freed the register
        if (dealloc_state) begin
          next_state = preg_pkg::IDLE;
        end
      end
      default: begin
        next_state = preg_pkg::IDLE;
      end
    endcase
  end

  assign wb_done = (state == preg_pkg::WB);

  // Nothing writes a register that has no producer
  a_no_wb_when_free : assert property (
    @(posedge sm_clk) disable iff (!cpurst_b)
    !(wb_vld && dealloc_state)
  );

endmodule

// File: hdl/preg_release_decode.sv
module preg_release_decode (
  input  preg_pkg::preg_t                rel_preg,
  input  preg_pkg::areg_t                dst_reg,
  input  logic                           alloc_state,
  input  logic                           retire_state,
  input  logic                           release_state,
  input  logic                           retire_vld,
  input  logic                           wb_done,
  output logic [preg_pkg::PREG_NUM-1:0]  rel_preg_expand,
  output logic [preg_pkg::AREG_NUM-1:0]  dreg,
  output logic                           retired_released_wb
);

  logic [preg_pkg::PREG_NUM-1:0] rel_onehot;
  logic [preg_pkg::AREG_NUM-1:0] dst_onehot;
  logic                          rel_retire_vld;
  logic                          retiring;

  // ------------------------------------------------------------------
  // Release request for the old mapping
  // ------------------------------------------------------------------
  assign rel_onehot = {{(preg_pkg::PREG_NUM-1){1'b0}}, 1'b1} << rel_preg;

  // Match flags already carry the ALLOC check from one cycle earlier
  assign rel_retire_vld  = alloc_state && retire_vld;
  assign rel_preg_expand = {preg_pkg::PREG_NUM{rel_retire_vld}} & rel_onehot;

  // ------------------------------------------------------------------
  // Rename table recovery
  // ------------------------------------------------------------------
  assign dst_onehot = {{(preg_pkg::AREG_NUM-1){1'b0}}, 1'b1} << dst_reg;
  assign dreg       = {preg_pkg::AREG_NUM{retire_state}} & dst_onehot;

  // Written-back report, also covers the retiring cycle itself
  assign retiring            = rel_retire_vld || retire_state || release_state;
  assign retired_released_wb = retiring ? wb_done : 1'b1;

endmodule

// File: hdl/preg_entry.sv
module preg_entry (
  input  logic                                sm_clk,
  input  logic                                cpurst_b,
  input  logic                                flush,
  input  logic                                dealloc_vld,
  input  logic [preg_pkg::DISPATCH_SLOTS-1:0] create_sel,
  input  preg_pkg::iid_t                      dis_iid      [preg_pkg::DISPATCH_SLOTS],
  input  preg_pkg::areg_t                     dis_dst_reg  [preg_pkg::DISPATCH_SLOTS],
  input  preg_pkg::preg_t                     dis_rel_preg [preg_pkg::DISPATCH_SLOTS],
  input  logic [preg_pkg::RETIRE_SLOTS-1:0]   retire_updt_vld,
  input  preg_pkg::iid_t                      retire_updt_iid [preg_pkg::RETIRE_SLOTS],
  input  logic [preg_pkg::RETIRE_SLOTS-1:0]   retire_preg_vld,
  input  logic                                release_vld,
  input  logic                                wb_vld,
  output logic                                cur_state_dealloc,
  output logic [preg_pkg::PREG_NUM-1:0]       rel_preg_expand,
  output logic [preg_pkg::AREG_NUM-1:0]       dreg,
  output logic                                retired_released_wb
);

  logic            create_vld;
  preg_pkg::iid_t  iid;
  preg_pkg::areg_t dst_reg;
  preg_pkg::preg_t rel_preg;
  logic            retire_vld;
  logic            alloc_state;
  logic            retire_state;
  logic            release_state;
  logic            wb_done;

  // ------------------------------------------------------------------
  // Input side
  // ------------------------------------------------------------------
  dispatch_capture u_dispatch_capture (
    .sm_clk       (sm_clk),
    .cpurst_b     (cpurst_b),
    .create_sel   (create_sel),
    .dis_iid      (dis_iid),
    .dis_dst_reg  (dis_dst_reg),
    .dis_rel_preg (dis_rel_preg),
    .create_vld   (create_vld),
    .iid          (iid),
    .dst_reg      (dst_reg),
    .rel_preg     (rel_preg)
  );

  retire_match u_retire_match (
    .sm_clk          (sm_clk),
    .cpurst_b        (cpurst_b),
    .alloc_state     (alloc_state),
    .iid             (iid),
    .retire_updt_vld (retire_updt_vld),
    .retire_updt_iid (retire_updt_iid),
    .retire_preg_vld (retire_preg_vld),
    .retire_vld      (retire_vld)
  );

  // ------------------------------------------------------------------
  // State machines
  // ------------------------------------------------------------------
  preg_lifecycle_fsm u_preg_lifecycle_fsm (
    .sm_clk        (sm_clk),
    .cpurst_b      (cpurst_b),
    .flush         (flush),
    .dealloc_vld   (dealloc_vld),
    .create_vld    (create_vld),
    .retire_vld    (retire_vld),
    .release_vld   (release_vld),
    .wb_done       (wb_done),
    .dealloc_state (cur_state_dealloc),
    .alloc_state   (alloc_state),
    .retire_state  (retire_state),
    .release_state (release_state)
  );

  preg_wb_fsm u_preg_wb_fsm (
    .sm_clk        (sm_clk),
    .cpurst_b      (cpurst_b),
    .wb_vld        (wb_vld),
    .create_vld    (create_vld),
    .dealloc_state (cur_state_dealloc),
    .wb_done       (wb_done)
  );

  // Output side
  preg_release_decode u_preg_release_decode (
    .rel_preg            (rel_preg),
    .dst_reg             (dst_reg),
    .alloc_state         (alloc_state),
    .retire_state        (retire_state),
    .release_state       (release_state),
    .retire_vld          (retire_vld),
    .wb_done             (wb_done),
    .rel_preg_expand     (rel_preg_expand),
    .dreg                (dreg),
    .retired_released_wb (retired_released_wb)
  );

endmodule

// File: sim/preg_entry_checker.sv
module preg_entry_checker (
  input  logic                          sm_clk,
  input  logic                          row_active,
  input  int                            row_idx,
  input  logic [3:0]                    row_beh,
  input  logic                          exp_dealloc,
  input  logic [preg_pkg::PREG_NUM-1:0] exp_rel_vec,
  input  logic [preg_pkg::AREG_NUM-1:0] exp_dreg_vec,
  input  logic                          exp_rrwb,
  input  logic                          cur_state_dealloc,
  input  logic [preg_pkg::PREG_NUM-1:0] rel_preg_expand,
  input  logic [preg_pkg::AREG_NUM-1:0] dreg,
  input  logic                          retired_released_wb,
  output int                            test_count,
  output int                            fail_count,
  output int                            error_count
);
  timeunit 1ns;
  timeprecision 1ps;

  int row_errs;

  initial begin
    test_count  = 0;
    fail_count  = 0;
    error_count = 0;
    row_errs    = 0;
  end

  // Narrow outputs are widened to the release vector width
  task automatic compare_field(input string name,
                               input logic [preg_pkg::PREG_NUM-1:0] got,
                               input logic [preg_pkg::PREG_NUM-1:0] exp);
    if (got !== exp) begin
      $display("[ERROR] time %0t: %s expected %0h, got %0h", $time, name, exp, got);
      row_errs++;
      error_count++;
    end
  endtask

  // ------------------------------------------------------------------
  // Per row compare
  // ------------------------------------------------------------------
  // Inputs settle just after the rising edge, so the falling edge
  // sees stable combinational outputs
  always @(negedge sm_clk) begin
    if (row_active) begin
      row_errs = 0;
      compare_field("cur_state_dealloc", cur_state_dealloc, exp_dealloc);
      compare_field("rel_preg_expand", rel_preg_expand, exp_rel_vec);
      compare_field("dreg", dreg, exp_dreg_vec);
      compare_field("retired_released_wb", retired_released_wb, exp_rrwb);
      test_count++;
      if (row_errs == 0) begin
        $display("Test %0d (behavior %0d): ok", row_idx, row_beh);
      end else begin
        fail_count++;
        $display("Test %0d (behavior %0d): FAILED with %0d mismatches",
                 row_idx, row_beh, row_errs);
      end
    end
  end

endmodule

// File: sim/preg_entry_tb.sv
module preg_entry_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 8;
  localparam int DRIVE_DELAY  = 2;
  localparam int NUM_ROWS     = 20;

  // One clock cycle of stimulus and the outputs expected in that cycle
  typedef struct packed {
    logic [3:0] beh;
    logic       flush;
    logic       dealloc;
    logic [3:0] create_sel;
    logic [2:0] updt_vld;
    logic [2:0] updt_hit;
    logic [2:0] preg_vld;
    logic       rel_req;
    logic       wb;
    logic       exp_free;
    logic       exp_rel;
    logic       exp_dreg;
    logic       exp_wb;
  } row_t;

  row_t tbl [NUM_ROWS];
  int   fill_idx;

  logic                                sm_clk;
  logic                                cpurst_b;
  logic                                flush;
  logic                                dealloc_vld;
  logic [preg_pkg::DISPATCH_SLOTS-1:0] create_sel;
  preg_pkg::iid_t                      dis_iid      [preg_pkg::DISPATCH_SLOTS];
  preg_pkg::areg_t                     dis_dst_reg  [preg_pkg::DISPATCH_SLOTS];
  preg_pkg::preg_t                     dis_rel_preg [preg_pkg::DISPATCH_SLOTS];
  logic [preg_pkg::RETIRE_SLOTS-1:0]   retire_updt_vld;
  preg_pkg::iid_t                      retire_updt_iid [preg_pkg::RETIRE_SLOTS];
  logic [preg_pkg::RETIRE_SLOTS-1:0]   retire_preg_vld;
  logic                                release_vld;
  logic                                wb_vld;
  logic                                cur_state_dealloc;
  logic [preg_pkg::PREG_NUM-1:0]       rel_preg_expand;
  logic [preg_pkg::AREG_NUM-1:0]       dreg;
  logic                                retired_released_wb;

  // Fields handed to the entry by the last create
  preg_pkg::iid_t  cur_iid;
  preg_pkg::areg_t cur_dst;
  preg_pkg::preg_t cur_rel;

  logic                          row_active;
  int                            row_idx;
  logic [3:0]                    row_beh;
  logic                          exp_dealloc;
  logic [preg_pkg::PREG_NUM-1:0] exp_rel_vec;
  logic [preg_pkg::AREG_NUM-1:0] exp_dreg_vec;
  logic                          exp_rrwb;
  int                            test_count;
  int                            fail_count;
  int                            error_count;

  always #(CLK_PERIOD / 2) sm_clk = ~sm_clk;

  preg_entry u_preg_entry (
    .sm_clk              (sm_clk),
    .cpurst_b            (cpurst_b),
    .flush               (flush),
    .dealloc_vld         (dealloc_vld),
    .create_sel          (create_sel),
    .dis_iid             (dis_iid),
    .dis_dst_reg         (dis_dst_reg),
    .dis_rel_preg        (dis_rel_preg),
    .retire_updt_vld     (retire_updt_vld),
    .retire_updt_iid     (retire_updt_iid),
    .retire_preg_vld     (retire_preg_vld),
    .release_vld         (release_vld),
    .wb_vld              (wb_vld),
    .cur_state_dealloc   (cur_state_dealloc),
    .rel_preg_expand     (rel_preg_expand),
    .dreg                (dreg),
    .retired_released_wb (retired_released_wb)
  );

  preg_entry_checker u_checker (
    .sm_clk              (sm_clk),
    .row_active          (row_active),
    .row_idx             (row_idx),
    .row_beh             (row_beh),
    .exp_dealloc         (exp_dealloc),
    .exp_rel_vec         (exp_rel_vec),
    .exp_dreg_vec        (exp_dreg_vec),
    .exp_rrwb            (exp_rrwb),
    .cur_state_dealloc   (cur_state_dealloc),
    .rel_preg_expand     (rel_preg_expand),
    .dreg                (dreg),
    .retired_released_wb (retired_released_wb),
    .test_count          (test_count),
    .fail_count          (fail_count),
    .error_count         (error_count)
  );

  task automatic add_row(input logic [3:0] beh, input logic fl, input logic dv,
                         input logic [3:0] sel, input logic [2:0] uv, input logic [2:0] uh,
                         input logic [2:0] pv, input logic rv, input logic wv,
                         input logic e_free, input logic e_rel, input logic e_dreg,
                         input logic e_wb);
    tbl[fill_idx] = '{beh, fl, dv, sel, uv, uh, pv, rv, wv, e_free, e_rel, e_dreg, e_wb};
    fill_idx++;
  endtask

  // ------------------------------------------------------------------
  // Stimulus table
  // ------------------------------------------------------------------
  // beh, flush, dealloc, create_sel, updt_vld, updt_hit, preg_vld, release, wb,
  // then expected free, release bit, dreg bit, written-back report
  task automatic build_table();
    add_row(4'd1, 0, 0, 4'b0000, 3'b000, 3'b000, 3'b000, 0, 0, 1, 0, 0, 1);
    add_row(4'd2, 0, 1, 4'b0000, 3'b000, 3'b000, 3'b000, 0, 0, 1, 0, 0, 1);
    add_row(4'd2, 0, 0, 4'b0100, 3'b000, 3'b000, 3'b000, 0, 0, 0, 0, 0, 1);
    add_row(4'd2, 0, 0, 4'b0000, 3'b010, 3'b010, 3'b000, 0, 0, 0, 0, 0, 1);
    add_row(4'd2, 0, 0, 4'b0000, 3'b000, 3'b000, 3'b010, 0, 0, 0, 1, 0, 0);
    add_row(4'd2, 0, 0, 4'b0000, 3'b000, 3'b000, 3'b000, 0, 0, 0, 0, 1, 0);
    // Release without write-back, then the late write-back
    add_row(4'd4, 0, 0, 4'b0000, 3'b000, 3'b000, 3'b000, 1, 0, 0, 0, 1, 0);
    add_row(4'd4, 0, 0, 4'b0000, 3'b000, 3'b000, 3'b000, 0, 0, 0, 0, 0, 0);
    add_row(4'd4, 0, 0, 4'b0000, 3'b000, 3'b000, 3'b000, 0, 1, 0, 0, 0, 0);
    add_row(4'd4, 0, 0, 4'b0000, 3'b000, 3'b000, 3'b000, 0, 0, 0, 0, 0, 1);
    add_row(4'd4, 0, 0, 4'b0000, 3'b000, 3'b000, 3'b000, 0, 0, 1, 0, 0, 1);
    // Slot 0 sees a wrong id, slot 2 was never updated
    add_row(4'd3, 0, 1, 4'b0000, 3'b000, 3'b000, 3'b000, 0, 0, 1, 0, 0, 1);
    add_row(4'd3, 0, 0, 4'b0001, 3'b000, 3'b000, 3'b000, 0, 0, 0, 0, 0, 1);
    add_row(4'd3, 0, 0, 4'b0000, 3'b001, 3'b000, 3'b000, 0, 0, 0, 0, 0, 1);
    add_row(4'd3, 0, 0, 4'b0000, 3'b000, 3'b000, 3'b101, 0, 0, 0, 0, 0, 1);
    add_row(4'd3, 0, 0, 4'b0000, 3'b000, 3'b000, 3'b000, 0, 0, 0, 0, 0, 1);
    // Flush after a matching update
    add_row(4'd5, 0, 0, 4'b0000, 3'b010, 3'b010, 3'b000, 0, 0, 0, 0, 0, 1);
    add_row(4'd5, 1, 0, 4'b0000, 3'b000, 3'b000, 3'b000, 0, 0, 0, 0, 0, 1);
    add_row(4'd5, 0, 0, 4'b0000, 3'b000, 3'b000, 3'b010, 0, 0, 1, 0, 0, 1);
    add_row(4'd5, 0, 0, 4'b0000, 3'b000, 3'b000, 3'b000, 0, 0, 1, 0, 0, 1);
  endtask

  function automatic preg_pkg::iid_t pick_other_iid(input preg_pkg::iid_t avoid);
    preg_pkg::iid_t v;
    v = avoid;
    while (v == avoid) begin
      v = preg_pkg::iid_t'($urandom);
    end
    return v;
  endfunction

  task automatic clear_inputs();
    flush           = 1'b0;
    dealloc_vld     = 1'b0;
    create_sel      = '0;
    retire_updt_vld = '0;
    retire_preg_vld = '0;
    release_vld     = 1'b0;
    wb_vld          = 1'b0;
    for (int i = 0; i < preg_pkg::DISPATCH_SLOTS; i++) begin
      dis_iid[i]      = '0;
      dis_dst_reg[i]  = '0;
      dis_rel_preg[i] = '0;
    end
    for (int k = 0; k < preg_pkg::RETIRE_SLOTS; k++) begin
      retire_updt_iid[k] = '0;
    end
  endtask

  task automatic drive_row(input row_t r);
    // Every slot gets fresh fields, only the selected one is kept
    for (int i = 0; i < preg_pkg::DISPATCH_SLOTS; i++) begin
      dis_iid[i]      = preg_pkg::iid_t'($urandom);
      dis_dst_reg[i]  = preg_pkg::areg_t'($urandom);
      dis_rel_preg[i] = preg_pkg::preg_t'($urandom % preg_pkg::PREG_NUM);
      if (r.create_sel[i]) begin
        cur_iid = dis_iid[i];
        cur_dst = dis_dst_reg[i];
        cur_rel = dis_rel_preg[i];
      end
    end
    for (int k = 0; k < preg_pkg::RETIRE_SLOTS; k++) begin
      retire_updt_iid[k] = r.updt_hit[k] ? cur_iid : pick_other_iid(cur_iid);
    end
    flush           = r.flush;
    dealloc_vld     = r.dealloc;
    create_sel      = r.create_sel;
    retire_updt_vld = r.updt_vld;
    retire_preg_vld = r.preg_vld;
    release_vld     = r.rel_req;
    wb_vld          = r.wb;
    exp_dealloc  = r.exp_free;
    exp_rrwb     = r.exp_wb;
    exp_rel_vec  = '0;
    exp_dreg_vec = '0;
    if (r.exp_rel) begin
      exp_rel_vec[cur_rel] = 1'b1;
    end
    if (r.exp_dreg) begin
      exp_dreg_vec[cur_dst] = 1'b1;
    end
  endtask

  // ------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------
  initial begin
    void'($urandom(34));
    sm_clk       = 1'b0;
    cpurst_b     = 1'b0;
    clear_inputs();
    row_active   = 1'b0;
    row_idx      = 0;
    row_beh      = '0;
    exp_dealloc  = 1'b1;
    exp_rel_vec  = '0;
    exp_dreg_vec = '0;
    exp_rrwb     = 1'b1;
    cur_iid      = '0;
    cur_dst      = '0;
    cur_rel      = '0;
    fill_idx     = 0;
    build_table();
    repeat (RESET_CYCLES) @(posedge sm_clk);
    #(DRIVE_DELAY);
    cpurst_b = 1'b1;
    for (int n = 0; n < NUM_ROWS; n++) begin
      @(posedge sm_clk);
      #(DRIVE_DELAY);
      drive_row(tbl[n]);
      row_idx    = n;
      row_beh    = tbl[n].beh;
      row_active = 1'b1;
    end
    @(posedge sm_clk);
    #(DRIVE_DELAY);
    row_active = 1'b0;
    clear_inputs();
    @(posedge sm_clk);
    $display("Tests run: %0d of %0d, failed: %0d, mismatches: %0d",
             test_count, NUM_ROWS, fail_count, error_count);
    if (error_count == 0 && fail_count == 0 && test_count == NUM_ROWS) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #((NUM_ROWS + 20) * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d clock cycles", NUM_ROWS + 20);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// File: src.f
hdl/preg_pkg.sv
hdl/dispatch_capture.sv
hdl/retire_match.sv
hdl/preg_lifecycle_fsm.sv
hdl/preg_wb_fsm.sv
hdl/preg_release_decode.sv
hdl/preg_entry.sv
sim/preg_entry_checker.sv
sim/preg_entry_tb.sv
